// File: storePkg.sv
package storePkg;

    // widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [6:0]  seqNum_t;     // wraps so order is a signed difference
    typedef logic [6:0]  tag_t;        // physical destination tag
    typedef logic [4:0]  regName_t;    // architectural destination register
    typedef logic [3:0]  byteMask_t;   // one bit per byte lane
    typedef logic [1:0]  modeFlags_t;

    localparam int MODE_NO_CREGS_WR = 0;  // no writes to 0xFFxxxxxx
    localparam int MODE_WMASK       = 1;  // region write mask active

    localparam int SQ_DEPTH = 4;
    localparam int SQ_PTR_W = 2;

    typedef logic [SQ_PTR_W-1:0] sqPtr_t;

    // everything from SB_I upward takes the base register as the address
    typedef enum logic [3:0] {
        SB,
        SH,
        SW,
        SB_I,
        SH_I,
        SW_I,
        CBO_CLEAN,
        CBO_INVAL,
        CBO_FLUSH,
        AMOSWAP_W
    } storeOp_t;

    typedef enum logic [1:0] {
        NONE,
        EXCEPT,
        ORDERING
    } resFlags_t;

    typedef struct packed {
        storeOp_t    opcode;
        word_t       srcA;      // base
        word_t       srcB;      // store data
        logic [11:0] imm;
        word_t       pc;
        tag_t        tagDst;
        regName_t    nmDst;
        seqNum_t     sqN;
    } exUop_t;

    typedef struct packed {
        logic    taken;
        seqNum_t sqN;
    } branchProv_t;

    typedef struct packed {
        logic      valid;
        tag_t      tagDst;
        regName_t  nmDst;
        seqNum_t   sqN;
        word_t     pc;
        resFlags_t flags;
        word_t     result;
    } resUop_t;

    typedef struct packed {
        word_t     addr;
        word_t     data;       // already laned
        byteMask_t wmask;
        seqNum_t   sqN;
        word_t     pc;
        logic      exception;
    } storeOp_s;

    typedef struct packed {
        word_t     addr;
        word_t     data;
        byteMask_t wmask;
    } memWrite_t;

    // a is younger than b when a - b is positive in two's complement
    function automatic logic isYounger(seqNum_t a, seqNum_t b);
        seqNum_t diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

// File: storeAgu.sv
`timescale 1ns/1ns

module storeAgu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  uopValid,
    input  storePkg::exUop_t      uop,
    output logic                  uopReady,
    input  storePkg::branchProv_t branch,
    input  storePkg::modeFlags_t  mode,
    input  logic [63:0]           wmask64,
    output storePkg::resUop_t     res,
    output logic                  aguValid,
    output storePkg::storeOp_s    aguOp,
    input  logic                  aguReady
);
    import storePkg::*;

    word_t     addrSum;
    word_t     effAddr;
    logic      isExcept;
    word_t     laneData;
    byteMask_t laneMask;
    resFlags_t nextFlags;
    storeOp_s  nextOp;
    logic      squashIn;
    logic      squashOut;
    logic      accept;

    assign addrSum = uop.srcA + {{20{uop.imm[11]}}, uop.imm};
    assign effAddr = (uop.opcode >= SB_I) ? uop.srcA : addrSum;

    always_comb begin
        case (uop.opcode)
            SB, SB_I:           isExcept = (effAddr == '0);
            SH, SH_I:           isExcept = (effAddr == '0) || effAddr[0];
            SW, SW_I, AMOSWAP_W: isExcept = (effAddr == '0) || (effAddr[1:0] != 2'b00);
            default:            isExcept = 1'b0;  // cache-block ops only see region checks
        endcase
        if (mode[MODE_NO_CREGS_WR] && effAddr[31:24] == 8'hFF) begin
            isExcept = 1'b1;  // control-register window
        end
        if (mode[MODE_WMASK] && !wmask64[effAddr[31:26]]) begin
            isExcept = 1'b1;  // 64 MB region locked
        end
    end

    // move the data into its byte lanes
    always_comb begin
        case (uop.opcode)
            SB, SB_I: begin
                laneMask = 4'b0001 << effAddr[1:0];
                laneData = uop.srcB << {effAddr[1:0], 3'b000};
            end
            SH, SH_I: begin
                laneMask = effAddr[1] ? 4'b1100 : 4'b0011;
                laneData = effAddr[1] ? (uop.srcB << 16) : uop.srcB;
            end
            SW, SW_I, AMOSWAP_W: begin
                laneMask = 4'b1111;
                laneData = uop.srcB;
            end
            CBO_CLEAN: begin
                laneMask = 4'b0000;
                laneData = 32'd0;  // operation code in bits 1:0
            end
            CBO_INVAL: begin
                laneMask = 4'b0000;
                laneData = 32'd1;
            end
            CBO_FLUSH: begin
                laneMask = 4'b0000;
                laneData = 32'd2;
            end
            default: begin
                laneMask = 4'b0000;
                laneData = uop.srcB;
            end
        endcase
    end

    always_comb begin
        if (uop.opcode == CBO_INVAL || uop.opcode == CBO_FLUSH) begin
            nextFlags = ORDERING;  // wins over a fault
        end else if (isExcept) begin
            nextFlags = EXCEPT;
        end else begin
            nextFlags = NONE;
        end
    end

    always_comb begin
        nextOp.addr      = effAddr;
        nextOp.data      = laneData;
        nextOp.wmask     = laneMask;
        nextOp.sqN       = uop.sqN;
        nextOp.pc        = uop.pc;
        nextOp.exception = isExcept;
    end

    assign squashIn  = branch.taken && isYounger(uop.sqN, branch.sqN);
    assign squashOut = branch.taken && aguValid && isYounger(aguOp.sqN, branch.sqN);
    assign uopReady  = !aguValid || aguReady;  // stall only when full and not taken
    assign accept    = uopValid && uopReady && !squashIn;

    always_ff @(posedge clk) begin
        if (accept) begin
            aguOp      <= nextOp;
            res.tagDst <= uop.tagDst;
            res.nmDst  <= uop.nmDst;
            res.sqN    <= uop.sqN;
            res.pc     <= uop.pc;
            res.flags  <= nextFlags;
            res.result <= addrSum;  // the sum even for _I forms
        end
        if (rst) begin
            aguValid  <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            res.valid <= accept;  // one pulse per accepted uop
            if (accept) begin
                aguValid <= 1'b1;
            end else if (aguReady || squashOut) begin
                aguValid <= 1'b0;
            end
        end
    end

    aguOpHeld: assert property (@(posedge clk) disable iff (rst)
        aguValid && !aguReady && !squashOut |=> aguValid && $stable(aguOp));

    // every result belongs to the store record that the same handshake loaded
    resNeedsAccept: assert property (@(posedge clk) disable iff (rst)
        res.valid |-> $past(uopValid && uopReady) && aguValid && (aguOp.sqN == res.sqN));

endmodule

// File: storeQueue.sv
`timescale 1ns/1ns

module storeQueue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  aguValid,
    input  storePkg::storeOp_s    aguOp,
    output logic                  aguReady,
    input  storePkg::branchProv_t branch,
    input  storePkg::seqNum_t     commitSqN,
    output logic                  memValid,
    output storePkg::memWrite_t   memReq,
    input  logic                  memReady
);
    import storePkg::*;

    storeOp_s              slots [SQ_DEPTH];
    logic [SQ_DEPTH-1:0]   slotValid;
    sqPtr_t                head;
    sqPtr_t                tail;      // next free slot
    storeOp_s              headOp;
    logic                  headValid;
    seqNum_t               commitDiff;
    logic                  eligible;
    logic                  pop;
    logic                  push;
    logic                  pushKilled;
    logic [SQ_DEPTH-1:0]   killMask;
    logic [SQ_PTR_W:0]     keepCnt;
    sqPtr_t                tailBase;

    assign headOp     = slots[head];
    assign headValid  = slotValid[head];
    assign commitDiff = commitSqN - headOp.sqN;
    assign eligible   = headValid && ($signed(commitDiff) >= 0);

    // faulting stores leave quietly
    assign memValid = eligible && !headOp.exception;
    assign pop      = eligible && (headOp.exception || memReady);

    assign memReq.addr  = headOp.addr;
    assign memReq.data  = headOp.data;
    assign memReq.wmask = headOp.wmask;

    assign aguReady   = !slotValid[tail];  // full when the tail slot is still taken
    assign pushKilled = branch.taken && isYounger(aguOp.sqN, branch.sqN);
    assign push       = aguValid && aguReady && !pushKilled;

    // live entries sit contiguous from head, so survivors form a prefix
    always_comb begin
        killMask = '0;
        keepCnt  = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            killMask[i] = branch.taken && slotValid[i]
                          && isYounger(slots[i].sqN, branch.sqN);
            if (slotValid[i] && !killMask[i]) begin
                keepCnt = keepCnt + 1'b1;
            end
        end
    end

    assign tailBase = branch.taken ? sqPtr_t'(head + keepCnt[SQ_PTR_W-1:0]) : tail;

    always_ff @(posedge clk) begin
        if (push) begin
            slots[tailBase] <= aguOp;
        end
        if (rst) begin
            slotValid <= '0;
            head      <= '0;
            tail      <= '0;
        end else begin
            slotValid <= slotValid & ~killMask;
            if (pop) begin
                slotValid[head] <= 1'b0;
                head            <= head + 1'b1;
            end else if (!headValid && head != tail) begin
                head <= head + 1'b1;  // skip a dead slot
            end
            if (push) begin
                slotValid[tailBase] <= 1'b1;
                tail                <= tailBase + 1'b1;
            end else begin
                tail <= tailBase;  // rollback on flush
            end
        end
    end

    // a ready queue is not full and its pointers agree with the valid bits
    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        aguValid && aguReady |-> $countones(slotValid) == int'(sqPtr_t'(tail - head)));

    memReqHeld: assert property (@(posedge clk) disable iff (rst)
        memValid && !memReady |=> $stable(memReq));

endmodule

// File: storeUnit.sv
`timescale 1ns/1ns

module storeUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  uopValid,
    input  storePkg::exUop_t      uop,
    output logic                  uopReady,
    input  storePkg::branchProv_t branch,
    input  storePkg::modeFlags_t  mode,
    input  logic [63:0]           wmask64,
    input  storePkg::seqNum_t     commitSqN,
    output storePkg::resUop_t     res,
    output logic                  memValid,
    output storePkg::memWrite_t   memReq,
    input  logic                  memReady
);
    import storePkg::*;

    logic     aguValid;
    logic     aguReady;
    storeOp_s aguOp;  // one laned store per transfer

    storeAgu agu (
        .clk(clk), .rst(rst),
        .uopValid(uopValid), .uop(uop), .uopReady(uopReady),
        .branch(branch), .mode(mode), .wmask64(wmask64),
        .res(res),
        .aguValid(aguValid), .aguOp(aguOp), .aguReady(aguReady)
    );

    storeQueue sq (
        .clk(clk), .rst(rst),
        .aguValid(aguValid), .aguOp(aguOp), .aguReady(aguReady),
        .branch(branch), .commitSqN(commitSqN),
        .memValid(memValid), .memReq(memReq), .memReady(memReady)
    );

endmodule

// File: tbClock.sv
`timescale 1ns/1ns

module tbClock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;  // released on the eighth rising edge
    end

endmodule

// File: storeUnitTb.sv
`timescale 1ns/1ns

module storeUnitTb;
    import storePkg::*;

    typedef struct packed {
        logic [2:0]  grp;
        logic        squash;    // issued together with a taken branch
        storeOp_t    op;
        word_t       base;
        word_t       data;
        logic [11:0] imm;
        seqNum_t     sqN;
        modeFlags_t  mode;
        logic [63:0] wmask;
        resFlags_t   flags;
        word_t       addr;      // expected memory address
        word_t       mdata;     // expected laned data
        byteMask_t   mask;
    } row_t;

    localparam int NROWS = 31;
    localparam int TIMEOUT = NROWS * 40 + 200;
    localparam logic [63:0] W1 = '1;
    localparam logic [63:0] WL = ~(64'd1 << 5);  // region 0x14000000 locked
    localparam seqNum_t BR_SQN = 7'd32;

    localparam row_t ROWS [NROWS] = '{
        // grp sq op base data imm sqN mode wmask flags addr mdata mask
        '{1, 0, SB, 32'h1000, 32'hA5, 12'h0, 7'd1, 0, W1, NONE, 32'h1000, 32'h000000A5, 4'h1},
        '{1, 0, SB, 32'h1000, 32'hA5, 12'h3, 7'd2, 0, W1, NONE, 32'h1003, 32'hA5000000, 4'h8},
        '{1, 0, SB, 32'h1001, 32'h3C, 12'h0, 7'd3, 0, W1, NONE, 32'h1001, 32'h00003C00, 4'h2},
        '{1, 0, SH, 32'h1000, 32'hBEEF, 12'h2, 7'd4, 0, W1, NONE, 32'h1002, 32'hBEEF0000, 4'hC},
        '{1, 0, SH, 32'h1004, 32'h1234, 12'h0, 7'd5, 0, W1, NONE, 32'h1004, 32'h00001234, 4'h3},
        '{1, 0, SW, 32'h1010, 32'hDEADBEEF, 12'hFFC, 7'd6, 0, W1, NONE, 32'h100C, 32'hDEADBEEF, 4'hF},
        '{1, 0, SB_I, 32'h2002, 32'h5A, 12'h10, 7'd7, 0, W1, NONE, 32'h2002, 32'h005A0000, 4'h4},
        '{1, 0, AMOSWAP_W, 32'h3000, 32'h5EED, 12'h0, 7'd8, 0, W1, NONE, 32'h3000, 32'h5EED, 4'hF},
        '{2, 0, SB, 32'h0, 32'h11, 12'h0, 7'd9, 0, W1, EXCEPT, 32'h0, 32'h0, 4'h0},
        '{2, 0, SH, 32'h1001, 32'h22, 12'h0, 7'd10, 0, W1, EXCEPT, 32'h1001, 32'h0, 4'h0},
        '{2, 0, SW, 32'h1000, 32'h33, 12'h2, 7'd11, 0, W1, EXCEPT, 32'h1002, 32'h0, 4'h0},
        '{2, 0, SW, 32'hFF000000, 32'h44, 12'h0, 7'd12, 1, W1, EXCEPT, 32'hFF000000, 32'h0, 4'h0},
        '{2, 0, SW, 32'h14000000, 32'h55, 12'h0, 7'd13, 2, WL, EXCEPT, 32'h14000000, 32'h0, 4'h0},
        '{3, 0, CBO_CLEAN, 32'h4000, 32'hFF, 12'h0, 7'd14, 0, W1, NONE, 32'h4000, 32'h0, 4'h0},
        '{3, 0, CBO_INVAL, 32'h4000, 32'hFF, 12'h0, 7'd15, 0, W1, ORDERING, 32'h4000, 32'h1, 4'h0},
        '{3, 0, CBO_FLUSH, 32'h4040, 32'hFF, 12'h0, 7'd16, 0, W1, ORDERING, 32'h4040, 32'h2, 4'h0},
        '{4, 0, SW, 32'h5000, 32'h11111111, 12'h0, 7'd17, 0, W1, NONE, 32'h5000, 32'h11111111, 4'hF},
        '{4, 0, SH, 32'h5006, 32'h2222, 12'h0, 7'd18, 0, W1, NONE, 32'h5006, 32'h22220000, 4'hC},
        '{4, 0, SB, 32'h5009, 32'h33, 12'h0, 7'd19, 0, W1, NONE, 32'h5009, 32'h00003300, 4'h2},
        '{5, 0, SW, 32'h6000, 32'hA0, 12'h0, 7'd30, 0, W1, NONE, 32'h6000, 32'hA0, 4'hF},
        '{5, 0, SW, 32'h6004, 32'hA1, 12'h0, 7'd31, 0, W1, NONE, 32'h6004, 32'hA1, 4'hF},
        '{5, 0, SW, 32'h6008, 32'hA2, 12'h0, 7'd33, 0, W1, NONE, 32'h6008, 32'hA2, 4'hF},
        '{5, 0, SW, 32'h600C, 32'hA3, 12'h0, 7'd34, 0, W1, NONE, 32'h600C, 32'hA3, 4'hF},
        '{5, 1, SW, 32'h6010, 32'hA4, 12'h0, 7'd35, 0, W1, NONE, 32'h6010, 32'hA4, 4'hF},
        '{6, 0, SW, 32'h7000, 32'hD0, 12'h0, 7'd36, 0, W1, NONE, 32'h7000, 32'hD0, 4'hF},
        '{6, 0, SH, 32'h7002, 32'h7777, 12'h0, 7'd37, 0, W1, NONE, 32'h7002, 32'h77770000, 4'hC},
        '{6, 0, SW_I, 32'h7008, 32'hD2, 12'h4, 7'd38, 0, W1, NONE, 32'h7008, 32'hD2, 4'hF},
        '{6, 0, SB, 32'h7003, 32'h99, 12'h0, 7'd39, 0, W1, NONE, 32'h7003, 32'h99000000, 4'h8},
        '{6, 0, SW, 32'h7010, 32'hD4, 12'h0, 7'd40, 0, W1, NONE, 32'h7010, 32'hD4, 4'hF},
        '{6, 0, SW, 32'h7014, 32'hD5, 12'h0, 7'd41, 0, W1, NONE, 32'h7014, 32'hD5, 4'hF},
        '{6, 0, SW, 32'h7018, 32'hD6, 12'h0, 7'd42, 0, W1, NONE, 32'h7018, 32'hD6, 4'hF}
    };

    string names [1:6] = '{"address and laning", "exceptions", "cache-block ops",
                           "commit gating", "branch flush", "back-pressure"};

    logic        clk;
    logic        rst;
    logic        uopValid;
    exUop_t      uop;
    logic        uopReady;
    branchProv_t branch;
    modeFlags_t  mode;
    logic [63:0] wmask64;
    seqNum_t     commitSqN;
    resUop_t     res;
    logic        memValid;
    memWrite_t   memReq;
    logic        memReady;

    resUop_t   resQ [$];      // results still to come, in issue order
    memWrite_t memQ [$];      // memory writes still to come, in program order
    seqNum_t   memSqQ [$];
    memWrite_t heldReq;
    logic      memStalled = 1'b0;
    logic      autoCommit = 1'b1;
    logic      holdCommit = 1'b0;
    logic      randStall  = 1'b0;
    logic      sawStall   = 1'b0;
    int        errCount   = 0;
    int        checkCount = 0;

    tbClock clkGen (.clk(clk), .rst(rst));

    storeUnit DUT (
        .clk(clk), .rst(rst),
        .uopValid(uopValid), .uop(uop), .uopReady(uopReady),
        .branch(branch), .mode(mode), .wmask64(wmask64), .commitSqN(commitSqN),
        .res(res),
        .memValid(memValid), .memReq(memReq), .memReady(memReady)
    );

    task automatic checkEq(input string name, input logic [95:0] exp, input logic [95:0] act);
        checkCount++;
        if (exp !== act) begin
            $display("** Error: %s expected %0h got %0h at %0t", name, exp, act, $time);
            errCount++;
        end
    endtask

    task automatic failNote(input string msg);
        $display("error: %s at %0t", msg, $time);
        errCount++;
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #2;
        memReady = randStall ? ($urandom % 5 == 0) : 1'b1;  // about one ready in five
    endtask

    task automatic driveUop(input int i);
        uop        = '0;
        uop.opcode = ROWS[i].op;
        uop.srcA   = ROWS[i].base;
        uop.srcB   = ROWS[i].data;
        uop.imm    = ROWS[i].imm;
        uop.pc     = 32'h100 + word_t'(i * 4);
        uop.tagDst = 7'(i);
        uop.nmDst  = 5'(i);
        uop.sqN    = ROWS[i].sqN;
        mode       = ROWS[i].mode;
        wmask64    = ROWS[i].wmask;
        uopValid   = 1'b1;
    endtask

    task automatic issueRow(input int i);
        resUop_t   r;
        memWrite_t m;
        driveUop(i);
        if (autoCommit) begin
            commitSqN = ROWS[i].sqN;
        end
        @(negedge clk);
        while (!uopReady) begin
            nextCycle();
            @(negedge clk);
        end
        r        = '0;
        r.tagDst = uop.tagDst;
        r.nmDst  = uop.nmDst;
        r.pc     = uop.pc;
        r.sqN    = ROWS[i].sqN;
        r.flags  = ROWS[i].flags;
        r.result = ROWS[i].base + word_t'($signed(ROWS[i].imm));  // always the sum
        resQ.push_back(r);
        if (ROWS[i].flags != EXCEPT) begin
            m.addr  = ROWS[i].addr;
            m.data  = ROWS[i].mdata;
            m.wmask = ROWS[i].mask;
            memQ.push_back(m);
            memSqQ.push_back(ROWS[i].sqN);
        end
        nextCycle();
        uopValid = 1'b0;
    endtask

    // the uop dies with the branch, as do all queued stores younger than it
    task automatic squashRow(input int i);
        driveUop(i);
        branch.taken = 1'b1;
        branch.sqN   = BR_SQN;
        for (int k = memQ.size() - 1; k >= 0; k--) begin
            if ($signed(seqNum_t'(memSqQ[k] - BR_SQN)) > 0) begin
                memQ.delete(k);
                memSqQ.delete(k);
            end
        end
        nextCycle();
        branch.taken = 1'b0;
        uopValid     = 1'b0;
    endtask

    task automatic waitDrain();
        while (memQ.size() != 0 || resQ.size() != 0) begin
            nextCycle();
        end
        repeat (4) nextCycle();  // faulting stores retire silently
    endtask

    always @(negedge clk) begin
        resUop_t   r;
        memWrite_t m;
        if (!rst) begin
            if (uopValid && !uopReady) begin
                sawStall = 1'b1;
            end
            if (res.valid && resQ.size() == 0) begin
                failNote("result without an accepted store");
            end else if (res.valid) begin
                r = resQ.pop_front();
                checkEq("res.flags", r.flags, res.flags);
                checkEq("res.result", r.result, res.result);
                checkEq("res.sqN", r.sqN, res.sqN);
                checkEq("res.tagDst", r.tagDst, res.tagDst);
                checkEq("res.nmDst", r.nmDst, res.nmDst);
                checkEq("res.pc", r.pc, res.pc);
            end
            if (memValid && holdCommit) begin
                failNote("memory write before commit");
            end
            if (memValid && memStalled) begin
                checkEq("memReq", heldReq, memReq);  // must hold through a stall
            end
            memStalled = memValid && !memReady;
            heldReq    = memReq;
            if (memValid && memReady && memQ.size() == 0) begin
                failNote("unexpected memory write");
            end else if (memValid && memReady) begin
                m = memQ.pop_front();
                void'(memSqQ.pop_front());
                checkEq("memReq.addr", m.addr, memReq.addr);
                checkEq("memReq.data", m.data, memReq.data);
                checkEq("memReq.wmask", m.wmask, memReq.wmask);
            end
        end
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int errBefore;
        void'($urandom(32'h2590_030c));
        uopValid  = 1'b0;
        uop       = '0;
        branch    = '0;
        mode      = '0;
        wmask64   = '1;
        commitSqN = '0;
        memReady  = 1'b1;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        checkEq("uopReady", 1'b1, uopReady);
        checkEq("aguValid", 1'b0, DUT.aguValid);
        checkEq("memValid", 1'b0, memValid);
        checkEq("res.valid", 1'b0, res.valid);
        nextCycle();
        for (int g = 1; g <= 6; g++) begin
            errBefore  = errCount;
            autoCommit = (g != 4) && (g != 5);
            holdCommit = (g == 4) || (g == 5);  // commit stays behind these stores
            randStall  = (g == 6);
            sawStall   = 1'b0;
            for (int i = 0; i < NROWS; i++) begin
                if (ROWS[i].grp == g && ROWS[i].squash) begin
                    squashRow(i);
                end else if (ROWS[i].grp == g) begin
                    issueRow(i);
                end
            end
            if (g == 4) begin
                repeat (10) nextCycle();
            end
            holdCommit = 1'b0;
            if (g == 4) begin
                commitSqN = 7'd19;
            end else if (g == 5) begin
                commitSqN = 7'd34;
            end
            waitDrain();
            if (g == 6 && !sawStall) begin
                failNote("uopReady never fell while the queue was full");
            end
            $display("test %0d (%s): %0d errors", g, names[g], errCount - errBefore);
        end
        $display("6 tests, %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sources.f
storePkg.sv
storeAgu.sv
storeQueue.sv
storeUnit.sv
tbClock.sv
storeUnitTb.sv

// File: Bender.yml
package:
  name: storeunit

sources:
  - storePkg.sv
  - storeAgu.sv
  - storeQueue.sv
  - storeUnit.sv
  - target: test
    files:
      - tbClock.sv
      - storeUnitTb.sv

# top level: storeUnit
# testbench top: storeUnitTb
